// File: hdl/udp_bridge_pkg.sv
package udp_bridge_pkg;

  // axi data path, one 32-bit word per beat
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int ADDR_W   = 32;
  localparam int ID_W     = 6;
  localparam int LEN_W    = 8;

  // byte offset bits inside one bus word
  localparam int ADDR_LSB = 2;

  // payload buffers are 1 KB each
  localparam int BUF_AW   = 8;
  localparam int BYTE_AW  = 10;

  localparam int FRAME_LEN_W = 16;

  // axi burst type, reserved code 3 is handled like incr
  typedef enum logic [1:0] {
    BURST_FIXED = 2'd0,
    BURST_INCR  = 2'd1,
    BURST_WRAP  = 2'd2
  } burst_e;

  // only okay is ever returned
  typedef enum logic [1:0] {
    RESP_OKAY = 2'd0
  } resp_e;

  // apb word index, paddr[5:2]
  typedef enum logic [3:0] {
    REG_TX_LENGTH = 4'd8,
    REG_RX_LENGTH = 4'd9,
    REG_TX_CTR    = 4'd10
  } reg_addr_e;

endpackage

// File: hdl/axi_burst_slave.sv
`timescale 1ns/1ps

module axi_burst_slave (
  input  logic                                 aclk,
  input  logic                                 aresetn,
  input  logic [udp_bridge_pkg::ID_W-1:0]      awid,
  input  logic [udp_bridge_pkg::ADDR_W-1:0]    awaddr,
  input  logic [udp_bridge_pkg::LEN_W-1:0]     awlen,
  input  logic [2:0]                           awsize,
  input  logic [1:0]                           awburst,
  input  logic                                 awvalid,
  output logic                                 awready,
  input  logic [udp_bridge_pkg::DATA_W-1:0]    wdata,
  input  logic [udp_bridge_pkg::STRB_W-1:0]    wstrb,
  input  logic                                 wlast,
  input  logic                                 wvalid,
  output logic                                 wready,
  output logic [udp_bridge_pkg::ID_W-1:0]      bid,
  output logic [1:0]                           bresp,
  output logic                                 bvalid,
  input  logic                                 bready,
  input  logic [udp_bridge_pkg::ID_W-1:0]      arid,
  input  logic [udp_bridge_pkg::ADDR_W-1:0]    araddr,
  input  logic [udp_bridge_pkg::LEN_W-1:0]     arlen,
  input  logic [2:0]                           arsize,
  input  logic [1:0]                           arburst,
  input  logic                                 arvalid,
  output logic                                 arready,
  output logic [udp_bridge_pkg::ID_W-1:0]      rid,
  output logic [udp_bridge_pkg::DATA_W-1:0]    rdata,
  output logic [1:0]                           rresp,
  output logic                                 rlast,
  output logic                                 rvalid,
  input  logic                                 rready,
  output logic                                 txbuf_we,
  output logic [udp_bridge_pkg::BUF_AW-1:0]    txbuf_waddr,
  output logic [udp_bridge_pkg::DATA_W-1:0]    txbuf_wdata,
  output logic [udp_bridge_pkg::STRB_W-1:0]    txbuf_wstrb,
  output logic [udp_bridge_pkg::BUF_AW-1:0]    rxbuf_raddr,
  input  logic [udp_bridge_pkg::DATA_W-1:0]    rxbuf_rdata
);

  typedef enum logic [1:0] {IDLE, WRITE, WRESP, READ} state_e;

  state_e                              state;
  logic [udp_bridge_pkg::ID_W-1:0]     id_q;
  logic [udp_bridge_pkg::ADDR_W-1:0]   addr_q;
  logic [udp_bridge_pkg::ADDR_W-1:0]   next_addr;
  logic [udp_bridge_pkg::ADDR_W-1:0]   step;
  logic [udp_bridge_pkg::LEN_W-1:0]    len_q;
  logic [udp_bridge_pkg::LEN_W-1:0]    beat_cnt;
  logic [2:0]                          size_q;
  udp_bridge_pkg::burst_e              burst_q;
  logic                                fetch;

  // one burst at a time, so both responses echo the same latched id
  assign bid   = id_q;
  assign rid   = id_q;
  assign bresp = udp_bridge_pkg::RESP_OKAY;
  assign rresp = udp_bridge_pkg::RESP_OKAY;

  // bytes per beat from the latched size
  assign step = {{(udp_bridge_pkg::ADDR_W - 1){1'b0}}, 1'b1} << size_q;

  // fixed holds, incr (and wrap, reserved) aligns then steps
  always_comb begin
    if (burst_q == udp_bridge_pkg::BURST_FIXED) begin
      next_addr = addr_q;
    end else begin
      next_addr = (addr_q & ~(step - 1'b1)) + step;
    end
  end

  assign txbuf_we    = wready & wvalid;
  assign txbuf_waddr = addr_q[udp_bridge_pkg::ADDR_LSB +: udp_bridge_pkg::BUF_AW];
  assign txbuf_wdata = wdata;
  assign txbuf_wstrb = wstrb;

  // look ahead on an r handshake so the next word is ready after one gap cycle
  assign rxbuf_raddr = (rvalid & rready & ~rlast) ?
                       next_addr[udp_bridge_pkg::ADDR_LSB +: udp_bridge_pkg::BUF_AW] :
                       addr_q[udp_bridge_pkg::ADDR_LSB +: udp_bridge_pkg::BUF_AW];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state   <= IDLE;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      fetch   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // write side wins when both are pending
          if (awvalid) begin
            awready <= 1'b1;
            state   <= WRITE;
          end else if (arvalid) begin
            arready <= 1'b1;
            state   <= READ;
          end
        end
        WRITE: begin
          if (awready) begin
            awready <= 1'b0;
            wready  <= 1'b1;
          end else if (wready && wvalid && wlast) begin
            wready <= 1'b0;
            bvalid <= 1'b1;
            state  <= WRESP;
          end
        end
        WRESP: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= IDLE;
          end
        end
        READ: begin
          if (arready) begin
            arready <= 1'b0;
            fetch   <= 1'b1;
          end else if (fetch) begin
            fetch  <= 1'b0;
            rvalid <= 1'b1;
            rlast  <= (beat_cnt == len_q);
          end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            if (rlast) begin
              state <= IDLE;
            end else begin
              fetch <= 1'b1;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // burst context and read data
  always_ff @(posedge aclk) begin
    if (state == IDLE) begin
      if (awvalid) begin
        id_q     <= awid;
        addr_q   <= awaddr;
        len_q    <= awlen;
        size_q   <= awsize;
        burst_q  <= udp_bridge_pkg::burst_e'(awburst);
        beat_cnt <= '0;
      end else if (arvalid) begin
        id_q     <= arid;
        addr_q   <= araddr;
        len_q    <= arlen;
        size_q   <= arsize;
        burst_q  <= udp_bridge_pkg::burst_e'(arburst);
        beat_cnt <= '0;
      end
    end
    if (txbuf_we || (rvalid && rready)) begin
      addr_q   <= next_addr;
      beat_cnt <= beat_cnt + 1'b1;
    end
    if (fetch) begin
      rdata <= rxbuf_rdata;
    end
  end

endmodule

// File: hdl/udp_cfg_regs.sv
`timescale 1ns/1ps

module udp_cfg_regs (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic                                   psel,
  input  logic                                   penable,
  input  logic                                   pwrite,
  input  logic [udp_bridge_pkg::ADDR_W-1:0]      paddr,
  input  logic [udp_bridge_pkg::DATA_W-1:0]      pwdata,
  output logic [udp_bridge_pkg::DATA_W-1:0]      prdata,
  output logic                                   pready,
  output logic                                   tx_start,
  output logic [udp_bridge_pkg::FRAME_LEN_W-1:0] tx_length,
  input  logic                                   tx_done,
  input  logic                                   rx_done,
  input  logic [udp_bridge_pkg::FRAME_LEN_W-1:0] rx_length,
  output logic                                   irq
);

  udp_bridge_pkg::reg_addr_e               reg_idx;
  logic                                    wr_en;
  logic                                    rd_en;
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  tx_length_q;
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  rx_length_q;
  logic                                    tx_busy;
  logic                                    irq_q;

  assign reg_idx = udp_bridge_pkg::reg_addr_e'(paddr[5:2]);
  // apb completes in the access phase
  assign wr_en   = psel & penable & pwrite;
  assign rd_en   = psel & penable & ~pwrite;
  assign pready  = psel & penable;

  assign tx_start  = tx_busy;
  assign tx_length = tx_length_q;
  assign irq       = irq_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      tx_length_q <= '0;
      rx_length_q <= '0;
      tx_busy     <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      if (wr_en && reg_idx == udp_bridge_pkg::REG_TX_LENGTH) begin
        tx_length_q <= pwdata[udp_bridge_pkg::FRAME_LEN_W-1:0];
      end
      // a new start request beats a finishing frame
      if (wr_en && reg_idx == udp_bridge_pkg::REG_TX_CTR) begin
        tx_busy <= pwdata[0];
      end else if (tx_done) begin
        tx_busy <= 1'b0;
      end
      if (rx_done) begin
        rx_length_q <= rx_length;
      end
      // frame end sets, reading the length acknowledges
      if (rx_done) begin
        irq_q <= 1'b1;
      end else if (rd_en && reg_idx == udp_bridge_pkg::REG_RX_LENGTH) begin
        irq_q <= 1'b0;
      end
    end
  end

  always_comb begin
    prdata = '0;
    case (reg_idx)
      udp_bridge_pkg::REG_TX_LENGTH: prdata[udp_bridge_pkg::FRAME_LEN_W-1:0] = tx_length_q;
      udp_bridge_pkg::REG_RX_LENGTH: prdata[udp_bridge_pkg::FRAME_LEN_W-1:0] = rx_length_q;
      udp_bridge_pkg::REG_TX_CTR:    prdata[0] = tx_busy;
      default:                       prdata = '0;
    endcase
  end

endmodule

// File: hdl/tx_streamer.sv
`timescale 1ns/1ps

module tx_streamer (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic                                   txbuf_we,
  input  logic [udp_bridge_pkg::BUF_AW-1:0]      txbuf_waddr,
  input  logic [udp_bridge_pkg::DATA_W-1:0]      txbuf_wdata,
  input  logic [udp_bridge_pkg::STRB_W-1:0]      txbuf_wstrb,
  input  logic                                   tx_start,
  input  logic [udp_bridge_pkg::FRAME_LEN_W-1:0] tx_length,
  output logic                                   tx_done,
  output logic [7:0]                             tx_tdata,
  output logic                                   tx_tvalid,
  output logic                                   tx_tlast,
  input  logic                                   tx_tready
);

  typedef enum logic {IDLE, SEND} state_e;

  state_e                                  state;
  logic [udp_bridge_pkg::DATA_W-1:0]       mem [2**udp_bridge_pkg::BUF_AW];
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  len_q;
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  cnt_q;
  logic [udp_bridge_pkg::BYTE_AW-1:0]      byte_idx;
  logic [udp_bridge_pkg::DATA_W-1:0]       rd_word;

  // byte-strobed writes from the axi side
  always_ff @(posedge aclk) begin
    if (txbuf_we) begin
      for (int i = 0; i < udp_bridge_pkg::STRB_W; i++) begin
        if (txbuf_wstrb[i]) begin
          mem[txbuf_waddr][8*i +: 8] <= txbuf_wdata[8*i +: 8];
        end
      end
    end
  end

  // buffer position wraps at 1 KB, frame count does not
  assign byte_idx = cnt_q[udp_bridge_pkg::BYTE_AW-1:0];
  assign rd_word  = mem[byte_idx[udp_bridge_pkg::BYTE_AW-1:udp_bridge_pkg::ADDR_LSB]];
  assign tx_tdata = rd_word[{byte_idx[udp_bridge_pkg::ADDR_LSB-1:0], 3'b000} +: 8];

  assign tx_tvalid = (state == SEND);
  assign tx_tlast  = tx_tvalid && (cnt_q == len_q - 1'b1);

  // zero length finishes straight from idle
  assign tx_done = (state == IDLE && tx_start && tx_length == '0) ||
                   (tx_tvalid && tx_tready && tx_tlast);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (tx_start && tx_length != '0) begin
            state <= SEND;
          end
        end
        SEND: begin
          if (tx_tready && tx_tlast) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == IDLE) begin
      len_q <= tx_length;
      cnt_q <= '0;
    end else if (tx_tready) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

endmodule

// File: hdl/rx_collector.sv
`timescale 1ns/1ps

module rx_collector (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic [7:0]                             rx_tdata,
  input  logic                                   rx_tvalid,
  input  logic                                   rx_tlast,
  input  logic [udp_bridge_pkg::BUF_AW-1:0]      rxbuf_raddr,
  output logic [udp_bridge_pkg::DATA_W-1:0]      rxbuf_rdata,
  output logic                                   rx_done,
  output logic [udp_bridge_pkg::FRAME_LEN_W-1:0] rx_length
);

  logic [udp_bridge_pkg::DATA_W-1:0]       mem [2**udp_bridge_pkg::BUF_AW];
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  count_q;
  logic [udp_bridge_pkg::BYTE_AW-1:0]      wr_idx;

  // byte k lands in lane k mod 4 of word k/4
  assign wr_idx = count_q[udp_bridge_pkg::BYTE_AW-1:0];

  always_ff @(posedge aclk) begin
    if (rx_tvalid) begin
      mem[wr_idx[udp_bridge_pkg::BYTE_AW-1:udp_bridge_pkg::ADDR_LSB]]
         [{wr_idx[udp_bridge_pkg::ADDR_LSB-1:0], 3'b000} +: 8] <= rx_tdata;
    end
    // registered word read for the axi side
    rxbuf_rdata <= mem[rxbuf_raddr];
  end

  // running byte count, cleared on frame end
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      count_q <= '0;
      rx_done <= 1'b0;
    end else begin
      rx_done <= rx_tvalid & rx_tlast;
      if (rx_tvalid) begin
        if (rx_tlast) begin
          count_q <= '0;
        end else begin
          count_q <= count_q + 1'b1;
        end
      end
    end
  end

  // length includes the tlast byte
  always_ff @(posedge aclk) begin
    if (rx_tvalid && rx_tlast) begin
      rx_length <= count_q + 1'b1;
    end
  end

endmodule

// File: hdl/udp_bridge_top.sv
`timescale 1ns/1ps

module udp_bridge_top (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic [udp_bridge_pkg::ID_W-1:0]     awid,
  input  logic [udp_bridge_pkg::ADDR_W-1:0]   awaddr,
  input  logic [udp_bridge_pkg::LEN_W-1:0]    awlen,
  input  logic [2:0]                          awsize,
  input  logic [1:0]                          awburst,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [udp_bridge_pkg::DATA_W-1:0]   wdata,
  input  logic [udp_bridge_pkg::STRB_W-1:0]   wstrb,
  input  logic                                wlast,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [udp_bridge_pkg::ID_W-1:0]     bid,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  logic [udp_bridge_pkg::ID_W-1:0]     arid,
  input  logic [udp_bridge_pkg::ADDR_W-1:0]   araddr,
  input  logic [udp_bridge_pkg::LEN_W-1:0]    arlen,
  input  logic [2:0]                          arsize,
  input  logic [1:0]                          arburst,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [udp_bridge_pkg::ID_W-1:0]     rid,
  output logic [udp_bridge_pkg::DATA_W-1:0]   rdata,
  output logic [1:0]                          rresp,
  output logic                                rlast,
  output logic                                rvalid,
  input  logic                                rready,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [udp_bridge_pkg::ADDR_W-1:0]   paddr,
  input  logic [udp_bridge_pkg::DATA_W-1:0]   pwdata,
  output logic [udp_bridge_pkg::DATA_W-1:0]   prdata,
  output logic                                pready,
  output logic [7:0]                          tx_tdata,
  output logic                                tx_tvalid,
  output logic                                tx_tlast,
  input  logic                                tx_tready,
  input  logic [7:0]                          rx_tdata,
  input  logic                                rx_tvalid,
  input  logic                                rx_tlast,
  output logic                                irq
);

  // axi to transmit buffer
  logic                                    txbuf_we;
  logic [udp_bridge_pkg::BUF_AW-1:0]       txbuf_waddr;
  logic [udp_bridge_pkg::DATA_W-1:0]       txbuf_wdata;
  logic [udp_bridge_pkg::STRB_W-1:0]       txbuf_wstrb;
  // axi from receive buffer
  logic [udp_bridge_pkg::BUF_AW-1:0]       rxbuf_raddr;
  logic [udp_bridge_pkg::DATA_W-1:0]       rxbuf_rdata;
  // frame control
  logic                                    tx_start;
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  tx_length;
  logic                                    tx_done;
  logic                                    rx_done;
  logic [udp_bridge_pkg::FRAME_LEN_W-1:0]  rx_length;

  axi_burst_slave i_axi (
    .aclk, .aresetn,
    .awid, .awaddr, .awlen, .awsize, .awburst, .awvalid, .awready,
    .wdata, .wstrb, .wlast, .wvalid, .wready,
    .bid, .bresp, .bvalid, .bready,
    .arid, .araddr, .arlen, .arsize, .arburst, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
    .txbuf_we, .txbuf_waddr, .txbuf_wdata, .txbuf_wstrb,
    .rxbuf_raddr, .rxbuf_rdata
  );

  udp_cfg_regs i_regs (
    .aclk, .aresetn,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .tx_start, .tx_length, .tx_done,
    .rx_done, .rx_length,
    .irq
  );

  tx_streamer i_tx (
    .aclk, .aresetn,
    .txbuf_we, .txbuf_waddr, .txbuf_wdata, .txbuf_wstrb,
    .tx_start, .tx_length, .tx_done,
    .tx_tdata, .tx_tvalid, .tx_tlast, .tx_tready
  );

  rx_collector i_rx (
    .aclk, .aresetn,
    .rx_tdata, .rx_tvalid, .rx_tlast,
    .rxbuf_raddr, .rxbuf_rdata,
    .rx_done, .rx_length
  );

endmodule

// File: test/udp_bridge_props.sv
`timescale 1ns/1ps

module udp_bridge_props (
  input logic                              aclk,
  input logic                              aresetn,
  input logic                              bvalid,
  input logic                              bready,
  input logic                              rvalid,
  input logic                              rready,
  input logic [udp_bridge_pkg::DATA_W-1:0] rdata,
  input logic                              tx_tvalid,
  input logic                              tx_tready,
  input logic                              irq
);

  // valid stays up until the sink takes it
  b_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid)
    else $error("rvalid dropped before rready");

  r_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> $stable(rdata))
    else $error("rdata changed while stalled");

  tx_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    tx_tvalid && !tx_tready |=> tx_tvalid)
    else $error("tx_tvalid dropped before tx_tready");

  // second reset cycle onward
  irq_rst: assert property (@(posedge aclk)
    !aresetn && $past(!aresetn) |-> !irq)
    else $error("irq high during reset");

endmodule

bind udp_bridge_top udp_bridge_props i_props (
  .aclk, .aresetn, .bvalid, .bready, .rvalid, .rready, .rdata,
  .tx_tvalid, .tx_tready, .irq
);

// File: test/udp_bridge_tb.sv
`timescale 1ns/1ps

module udp_bridge_tb;

  typedef logic [udp_bridge_pkg::DATA_W-1:0]      word_t;
  typedef logic [udp_bridge_pkg::STRB_W-1:0]      strb_t;
  typedef logic [udp_bridge_pkg::ID_W-1:0]        id_t;
  typedef logic [udp_bridge_pkg::FRAME_LEN_W-1:0] len_t;

  localparam int TXB = 0;
  localparam int RXB = 1;
  localparam int TIMEOUT = 2000;
  // which handshake signal a wait loop watches
  localparam int SEL_AWREADY = 0;
  localparam int SEL_WREADY  = 1;
  localparam int SEL_BVALID  = 2;
  localparam int SEL_ARREADY = 3;
  localparam int SEL_RVALID  = 4;

  logic                                aclk;
  logic                                aresetn;
  id_t                                 awid;
  logic [udp_bridge_pkg::ADDR_W-1:0]   awaddr;
  logic [udp_bridge_pkg::LEN_W-1:0]    awlen;
  logic [2:0]                          awsize;
  logic [1:0]                          awburst;
  logic                                awvalid;
  logic                                awready;
  word_t                               wdata;
  strb_t                               wstrb;
  logic                                wlast;
  logic                                wvalid;
  logic                                wready;
  id_t                                 bid;
  logic [1:0]                          bresp;
  logic                                bvalid;
  logic                                bready;
  id_t                                 arid;
  logic [udp_bridge_pkg::ADDR_W-1:0]   araddr;
  logic [udp_bridge_pkg::LEN_W-1:0]    arlen;
  logic [2:0]                          arsize;
  logic [1:0]                          arburst;
  logic                                arvalid;
  logic                                arready;
  id_t                                 rid;
  word_t                               rdata;
  logic [1:0]                          rresp;
  logic                                rlast;
  logic                                rvalid;
  logic                                rready;
  logic                                psel;
  logic                                penable;
  logic                                pwrite;
  logic [udp_bridge_pkg::ADDR_W-1:0]   paddr;
  word_t                               pwdata;
  word_t                               prdata;
  logic                                pready;
  logic [7:0]                          tx_tdata;
  logic                                tx_tvalid;
  logic                                tx_tlast;
  logic                                tx_tready;
  logic [7:0]                          rx_tdata;
  logic                                rx_tvalid;
  logic                                rx_tlast;
  logic                                irq;

  // shadow copy of the tx and rx payload buffers
  logic [7:0] shadow [2][1024];
  int         seed;
  int         errors;
  int         timeouts;
  logic       stall;
  string      test_name;
  // expectations handed to the compare process
  int         tx_len_exp;
  int         rd_base;
  int         rd_len_exp;
  id_t        rd_id_exp;
  // compare process state
  int         tx_idx = 0;
  int         tx_total = 0;
  int         rd_beat = 0;

  udp_bridge_top i_dut (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // random sink stalls while a frame is on the stream
  initial begin
    tx_tready = 1'b1;
    forever begin
      @(negedge aclk);
      tx_tready = !stall || !tx_tvalid || ($random(seed) % 3 != 0);
    end
  end

  function automatic logic [7:0] ref_byte(int b, int k);
    return shadow[b][k % 1024];
  endfunction

  // little endian, byte 4w+lane in lane
  function automatic word_t ref_word(int b, int w);
    word_t word;
    for (int lane = 0; lane < udp_bridge_pkg::STRB_W; lane++) begin
      word[8*lane +: 8] = shadow[b][4 * (w % 256) + lane];
    end
    return word;
  endfunction

  task automatic check_word(string name, word_t exp, word_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %h actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_byte(string name, logic [7:0] exp, logic [7:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %h actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_len(string name, len_t exp, len_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %0d actual %0d", test_name, name, exp, act);
    end
  endtask

  task automatic check_resp(string name, udp_bridge_pkg::resp_e exp,
                            udp_bridge_pkg::resp_e act);
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %0d actual %0d", test_name, name, exp, act);
    end
  endtask

  task automatic check_id(string name, id_t exp, id_t act);
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %h actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR [%s] %s: expected %b actual %b", test_name, name, exp, act);
    end
  endtask

  function automatic logic ready_of(int sel);
    case (sel)
      SEL_AWREADY: return awready;
      SEL_WREADY:  return wready;
      SEL_BVALID:  return bvalid;
      SEL_ARREADY: return arready;
      default:     return rvalid;
    endcase
  endfunction

  // returns on the falling edge before the handshake edge
  task automatic wait_for(int sel, string what);
    int cycles;
    cycles = 0;
    while (!ready_of(sel) && cycles < TIMEOUT) begin
      @(negedge aclk);
      cycles++;
    end
    if (!ready_of(sel)) begin
      timeouts++;
      $display("[%s] timed out waiting for %s", test_name, what);
    end
  endtask

  task automatic random_gap();
    int n;
    n = stall ? {$random(seed)} % 4 : 0;
    repeat (n) @(negedge aclk);
  endtask

  task automatic apb_write(udp_bridge_pkg::reg_addr_e idx, word_t data);
    @(negedge aclk);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = 32'(idx) << 2;
    pwdata  = data;
    @(negedge aclk);
    penable = 1'b1;
    @(negedge aclk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(udp_bridge_pkg::reg_addr_e idx, output word_t data);
    @(negedge aclk);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = 32'(idx) << 2;
    @(negedge aclk);
    penable = 1'b1;
    data    = prdata;
    @(negedge aclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic axi_write(id_t id, int word_base, int beats,
                           udp_bridge_pkg::burst_e burst, bit mixed);
    int    word;
    word_t data;
    strb_t strb;
    @(negedge aclk);
    awid    = id;
    awaddr  = 32'(word_base) << 2;
    awlen   = 8'(beats - 1);
    awsize  = 3'd2;
    awburst = burst;
    awvalid = 1'b1;
    wait_for(SEL_AWREADY, "awready");
    @(negedge aclk);
    awvalid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      random_gap();
      data = $random(seed);
      // first beat fills the word so later lane merges are defined
      strb = (mixed && i > 0) ? 4'($random(seed)) : 4'hf;
      word = (burst == udp_bridge_pkg::BURST_FIXED) ? word_base % 256 : (word_base + i) % 256;
      for (int lane = 0; lane < udp_bridge_pkg::STRB_W; lane++) begin
        if (strb[lane]) begin
          shadow[TXB][4 * word + lane] = data[8*lane +: 8];
        end
      end
      wdata  = data;
      wstrb  = strb;
      wlast  = (i == beats - 1);
      wvalid = 1'b1;
      wait_for(SEL_WREADY, "wready");
      @(negedge aclk);
      wvalid = 1'b0;
      wlast  = 1'b0;
    end
    wait_for(SEL_BVALID, "bvalid");
    check_id("bid", id, bid);
    check_resp("bresp", udp_bridge_pkg::RESP_OKAY, udp_bridge_pkg::resp_e'(bresp));
    random_gap();
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
  endtask

  task automatic axi_read(id_t id, int word_base, int beats);
    logic last;
    int   n;
    rd_base    = word_base;
    rd_len_exp = beats - 1;
    rd_id_exp  = id;
    @(negedge aclk);
    arid    = id;
    araddr  = 32'(word_base) << 2;
    arlen   = 8'(beats - 1);
    arsize  = 3'd2;
    arburst = udp_bridge_pkg::BURST_INCR;
    arvalid = 1'b1;
    wait_for(SEL_ARREADY, "arready");
    @(negedge aclk);
    arvalid = 1'b0;
    last = 1'b0;
    n = 0;
    while (!last && n <= beats) begin
      wait_for(SEL_RVALID, "rvalid");
      random_gap();
      last   = rlast;
      rready = 1'b1;
      @(negedge aclk);
      rready = 1'b0;
      n++;
    end
    check_len("r beat count", len_t'(beats), len_t'(n));
  endtask

  task automatic send_frame(int len);
    word_t ctr;
    int    polls;
    int    start_total;
    tx_len_exp  = len;
    start_total = tx_total;
    apb_write(udp_bridge_pkg::REG_TX_LENGTH, word_t'(len));
    apb_write(udp_bridge_pkg::REG_TX_CTR, 32'd1);
    ctr = 32'd1;
    polls = 0;
    while (ctr[0] && polls < TIMEOUT) begin
      apb_read(udp_bridge_pkg::REG_TX_CTR, ctr);
      polls++;
    end
    if (ctr[0]) begin
      timeouts++;
      $display("[%s] TX_CTR busy bit never cleared", test_name);
    end
    check_word("tx_ctr after frame", 32'd0, ctr);
    check_len("tx byte count", len_t'(len), len_t'(tx_total - start_total));
  endtask

  task automatic recv_frame(int len);
    word_t rd;
    int    cycles;
    for (int k = 0; k < len; k++) begin
      if ({$random(seed)} % 4 == 0) begin
        rx_tvalid = 1'b0;
        @(negedge aclk);
      end
      rx_tdata  = 8'($random(seed));
      shadow[RXB][k % 1024] = rx_tdata;
      rx_tlast  = (k == len - 1);
      rx_tvalid = 1'b1;
      @(negedge aclk);
    end
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    cycles = 0;
    while (!irq && cycles < TIMEOUT) begin
      @(negedge aclk);
      cycles++;
    end
    if (!irq) begin
      timeouts++;
      $display("[%s] irq did not rise after the receive frame", test_name);
    end
    apb_read(udp_bridge_pkg::REG_RX_LENGTH, rd);
    check_len("rx length", len_t'(len), len_t'(rd));
    @(negedge aclk);
    check_flag("irq after RX_LENGTH read", 1'b0, irq);
  endtask

  task automatic tx_burst_frame(int words);
    axi_write(id_t'($random(seed)), 0, words, udp_bridge_pkg::BURST_INCR, 1'b0);
    send_frame(1 + {$random(seed)} % (4 * words));
  endtask

  // compare process, sampled on the edge where the handshake happens
  always @(posedge aclk) begin
    if (aresetn && rvalid && rready) begin
      check_word("rdata", ref_word(RXB, rd_base + rd_beat), rdata);
      check_id("rid", rd_id_exp, rid);
      check_resp("rresp", udp_bridge_pkg::RESP_OKAY, udp_bridge_pkg::resp_e'(rresp));
      if (rlast) begin
        check_len("rlast beat", len_t'(rd_len_exp), len_t'(rd_beat));
        rd_beat = 0;
      end else begin
        rd_beat++;
      end
    end
    if (aresetn && tx_tvalid && tx_tready) begin
      check_byte("tx byte", ref_byte(TXB, tx_idx), tx_tdata);
      tx_total++;
      if (tx_tlast) begin
        check_len("tlast position", len_t'(tx_len_exp - 1), len_t'(tx_idx));
        tx_idx = 0;
      end else begin
        tx_idx++;
      end
    end
    // apb transfers complete in their access cycle
    if (aresetn && psel && penable) begin
      check_flag("pready", 1'b1, pready);
    end
  end

  initial begin
    word_t rd;
    int    len;
    seed      = 15758;
    errors    = 0;
    timeouts  = 0;
    stall     = 1'b0;
    test_name = "reset";
    aresetn   = 1'b0;
    awid      = '0;
    awaddr    = '0;
    awlen     = '0;
    awsize    = '0;
    awburst   = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wlast     = 1'b0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    arid      = '0;
    araddr    = '0;
    arlen     = '0;
    arsize    = '0;
    arburst   = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    rx_tdata  = '0;
    rx_tvalid = 1'b0;
    rx_tlast  = 1'b0;
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
    apb_read(udp_bridge_pkg::REG_TX_CTR, rd);
    check_word("tx_ctr after reset", 32'd0, rd);

    test_name = "incr_tx";
    tx_burst_frame(16);

    // word 1 merged over five beats, then bytes 0 to 7 sent out
    test_name = "fixed_strobe";
    axi_write(6'h2a, 1, 5, udp_bridge_pkg::BURST_FIXED, 1'b1);
    send_frame(8);

    test_name = "rx_frame";
    len = 9 + {$random(seed)} % 120;
    recv_frame(len);

    test_name = "rx_read";
    axi_read(6'h15, 0, len / 4);

    stall = 1'b1;
    test_name = "stall_tx";
    tx_burst_frame(32);
    test_name = "stall_read";
    axi_read(6'h33, 1, len / 4 - 1);
    stall = 1'b0;

    test_name = "zero_len";
    send_frame(0);

    $display("value errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
hdl/udp_bridge_pkg.sv
hdl/axi_burst_slave.sv
hdl/udp_cfg_regs.sv
hdl/tx_streamer.sv
hdl/rx_collector.sv
hdl/udp_bridge_top.sv
test/udp_bridge_props.sv
test/udp_bridge_tb.sv

// File: Makefile
# Verilator build and run for the AXI/APB payload bridge

VERILATOR ?= verilator
TOP       ?= udp_bridge_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
VFLAGS    ?= --timing --assert -Wno-fatal

SHELL := /bin/bash

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
